//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_mips_exec
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/data_mem.sv
rtl/mips_exec_top.sv
tests/tb_mips_exec.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module alu (
    input  logic [`MIPS_XLEN-1:0]    a,
    input  logic [`MIPS_XLEN-1:0]    b,
    input  mips_pkg::alu_op_e        op,
    input  logic [`MIPS_SHAMT_W-1:0] shamt,
    output logic [`MIPS_XLEN-1:0]    r
);

    // Add and subtract wrap, carry out is dropped
    logic [`MIPS_XLEN-1:0] sum;
    logic [`MIPS_XLEN-1:0] diff;

    // Unsigned less-than, zero-extended to a full word
    logic [`MIPS_XLEN-1:0] ltu;

    // Shift results, b is the value being shifted
    logic [`MIPS_XLEN-1:0] sll_r;
    logic [`MIPS_XLEN-1:0] srl_r;
    logic [`MIPS_XLEN-1:0] sra_r;

    assign sum  = a + b;
    assign diff = a - b;
    assign ltu  = {{(`MIPS_XLEN-1){1'b0}}, (a < b)};

    assign sll_r = b << shamt;
    assign srl_r = b >> shamt;
    // Sign bit of b fills from the left
    assign sra_r = $signed(b) >>> shamt;

    always_comb begin
        case (op)
            // Also used for ADDIU and the LW/SW address
            mips_pkg::ALU_ADD: begin
                r = sum;
            end
            mips_pkg::ALU_SUB: begin
                r = diff;
            end
            mips_pkg::ALU_AND: begin
                r = a & b;
            end
            mips_pkg::ALU_OR: begin
                r = a | b;
            end
            mips_pkg::ALU_XOR: begin
                r = a ^ b;
            end
            mips_pkg::ALU_SLTU: begin
                r = ltu;
            end
            mips_pkg::ALU_SLL: begin
                r = sll_r;
            end
            mips_pkg::ALU_SRL: begin
                r = srl_r;
            end
            mips_pkg::ALU_SRA: begin
                r = sra_r;
            end
            default: begin
                r = '0;
            end
        endcase
    end

endmodule

//--- rtl/data_mem.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module data_mem (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [`MIPS_DMEM_ADDR_W-1:0] addr,
    input  logic                         wr_en,
    input  logic [`MIPS_XLEN-1:0]        wr_data,
    output logic [`MIPS_XLEN-1:0]        rd_data
);

    // Word storage, indexed by word not byte
    logic [`MIPS_XLEN-1:0] mem [`MIPS_DMEM_DEPTH];

    // Clocked write
    // Contents start out zero after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    // Combinational read, sees a write only after its edge
    assign rd_data = mem[addr];

endmodule

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module instr_decoder (
    input  mips_pkg::instr_u  instr,
    output mips_pkg::decode_t dec
);

    // Both views of the same word
    mips_pkg::r_fields_t rf;
    mips_pkg::i_fields_t ifl;

    assign rf  = instr.r;
    assign ifl = instr.i;

    always_comb begin
        // Defaults: no side effects, add with register operand
        dec                  = '0;
        dec.alu_op           = mips_pkg::ALU_ADD;
        dec.b_sel            = mips_pkg::B_REG;
        dec.shift_from_shamt = 1'b0;

        // Sign-extended immediate, only used by I-type words
        dec.imm = {{(`MIPS_XLEN - `MIPS_IMM_W){ifl.imm[`MIPS_IMM_W-1]}}, ifl.imm};

        // Source registers sit at the same bits in both views
        dec.rs = rf.rs;
        dec.rt = rf.rt;

        if (rf.opcode == mips_pkg::OP_SPECIAL) begin
            // R view
            dec.dest      = rf.rd;
            dec.shamt     = rf.shamt;
            dec.reg_write = 1'b1;

            case (rf.funct)
                mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                mips_pkg::FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
                mips_pkg::FN_SLTU: dec.alu_op = mips_pkg::ALU_SLTU;
                // Fixed shifts take the amount from the shamt field
                mips_pkg::FN_SLL: begin
                    dec.alu_op           = mips_pkg::ALU_SLL;
                    dec.shift_from_shamt = 1'b1;
                end
                mips_pkg::FN_SRL: begin
                    dec.alu_op           = mips_pkg::ALU_SRL;
                    dec.shift_from_shamt = 1'b1;
                end
                mips_pkg::FN_SRA: begin
                    dec.alu_op           = mips_pkg::ALU_SRA;
                    dec.shift_from_shamt = 1'b1;
                end
                // Variable shifts take the amount from rs
                mips_pkg::FN_SLLV: dec.alu_op = mips_pkg::ALU_SLL;
                mips_pkg::FN_SRLV: dec.alu_op = mips_pkg::ALU_SRL;
                mips_pkg::FN_SRAV: dec.alu_op = mips_pkg::ALU_SRA;
                default: begin
                    // Unknown funct
                    dec.illegal   = 1'b1;
                    dec.reg_write = 1'b0;
                end
            endcase
        end else begin
            // I view, result goes to rt
            dec.dest  = ifl.rt;
            dec.b_sel = mips_pkg::B_IMM;

            case (ifl.opcode)
                mips_pkg::OP_ADDIU: begin
                    dec.reg_write = 1'b1;
                end
                mips_pkg::OP_LW: begin
                    // Address is rs + imm, data comes back from memory
                    dec.reg_write = 1'b1;
                    dec.mem_read  = 1'b1;
                end
                mips_pkg::OP_SW: begin
                    // rt is the store data here, not a destination
                    dec.mem_write = 1'b1;
                end
                default: begin
                    // Unknown opcode
                    dec.illegal = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path width, also the instruction word width
`define MIPS_XLEN 32

// Register index width
`define MIPS_REG_ADDR_W 5

// Number of architectural registers
`define MIPS_REG_COUNT (1 << `MIPS_REG_ADDR_W)

// Data memory word index width
`define MIPS_DMEM_ADDR_W 8

// Data memory depth in words
`define MIPS_DMEM_DEPTH (1 << `MIPS_DMEM_ADDR_W)

// Shift amount width, enough for any shift of an XLEN word
`define MIPS_SHAMT_W 5

// Immediate field width in the I-type word
`define MIPS_IMM_W 16

// Low byte address bits dropped to form a word index
`define MIPS_WORD_OFFSET_W 2

`endif

//--- rtl/mips_exec_top.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_exec_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               instr_valid,
    input  mips_pkg::instr_u   instr,
    output mips_pkg::retire_t  retire
);

    // Decoded fields
    mips_pkg::decode_t dec;

    // Operands and results
    logic [`MIPS_XLEN-1:0]        rs_data;
    logic [`MIPS_XLEN-1:0]        rt_data;
    logic [`MIPS_XLEN-1:0]        alu_b;
    logic [`MIPS_SHAMT_W-1:0]     alu_shamt;
    logic [`MIPS_XLEN-1:0]        alu_r;
    logic [`MIPS_DMEM_ADDR_W-1:0] mem_word;
    logic [`MIPS_XLEN-1:0]        mem_rdata;
    logic [`MIPS_XLEN-1:0]        wb_data;

    // Write strobes, only on an accepted instruction
    logic rf_wr_en;
    logic mem_wr_en;

    // Report for the instruction in flight
    mips_pkg::retire_t retire_next;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (dec.rs),
        .rt_addr (dec.rt),
        .wr_en   (rf_wr_en),
        .wr_addr (dec.dest),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // Second operand is rt or the extended immediate
    assign alu_b = (dec.b_sel == mips_pkg::B_IMM) ? dec.imm : rt_data;

    // Shift amount from shamt, or the low bits of rs for the V forms
    assign alu_shamt = dec.shift_from_shamt ? dec.shamt : rs_data[`MIPS_SHAMT_W-1:0];

    alu u_alu (
        .a     (rs_data),
        .b     (alu_b),
        .op    (dec.alu_op),
        .shamt (alu_shamt),
        .r     (alu_r)
    );

    // Byte address to word index, bits [9:2]
    assign mem_word = alu_r[`MIPS_DMEM_ADDR_W+`MIPS_WORD_OFFSET_W-1:`MIPS_WORD_OFFSET_W];

    assign mem_wr_en = instr_valid && dec.mem_write;

    data_mem u_data_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .addr    (mem_word),
        .wr_en   (mem_wr_en),
        .wr_data (rt_data),
        .rd_data (mem_rdata)
    );

    // LW writes back the memory word, everything else the ALU result
    assign wb_data  = dec.mem_read ? mem_rdata : alu_r;
    assign rf_wr_en = instr_valid && dec.reg_write && (dec.dest != '0);

    // Classify the instruction for its report
    always_comb begin
        retire_next         = '0;
        retire_next.valid   = instr_valid;
        retire_next.reg_idx = dec.dest;
        if (dec.mem_read || dec.mem_write) begin
            retire_next.addr = alu_r;
        end

        if (dec.illegal) begin
            retire_next.kind = mips_pkg::RET_ILLEGAL;
        end else if (dec.mem_write) begin
            // Store reports the address and the rt value
            retire_next.kind = mips_pkg::RET_STORE;
            retire_next.data = rt_data;
        end else if (dec.dest == '0) begin
            // Write aimed at register zero is dropped
            retire_next.kind = mips_pkg::RET_NONE;
        end else begin
            retire_next.kind = mips_pkg::RET_REG_WRITE;
            retire_next.data = wb_data;
        end
    end

    // Report goes out one cycle after the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire <= retire_next;
        end
    end

endmodule

//--- rtl/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    // Primary opcode, bits [31:26] of the word
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // Function code for SPECIAL words, bits [5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLTU = 6'b101011
    } funct_e;

    // R-type view of the word
    typedef struct packed {
        opcode_e                     opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        logic [`MIPS_SHAMT_W-1:0]    shamt;
        funct_e                      funct;
    } r_fields_t;

    // I-type view of the word
    typedef struct packed {
        opcode_e                     opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_IMM_W-1:0]      imm;
    } i_fields_t;

    // One instruction word, two decodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    // Internal ALU operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Source of the second ALU operand
    typedef enum logic {
        B_REG = 1'b0,
        B_IMM = 1'b1
    } operand_sel_e;

    // Decoder output
    typedef struct packed {
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] dest;
        logic [`MIPS_XLEN-1:0]       imm;
        alu_op_e                     alu_op;
        operand_sel_e                b_sel;
        logic                        shift_from_shamt;
        logic [`MIPS_SHAMT_W-1:0]    shamt;
        logic                        reg_write;
        logic                        mem_read;
        logic                        mem_write;
        logic                        illegal;
    } decode_t;

    // What a retired instruction did
    typedef enum logic [1:0] {
        RET_REG_WRITE = 2'd0,
        RET_STORE     = 2'd1,
        RET_NONE      = 2'd2,
        RET_ILLEGAL   = 2'd3
    } retire_kind_e;

    // Retire report, one per accepted instruction
    typedef struct packed {
        logic                        valid;
        retire_kind_e                kind;
        logic [`MIPS_REG_ADDR_W-1:0] reg_idx;
        logic [`MIPS_XLEN-1:0]       data;
        logic [`MIPS_XLEN-1:0]       addr;
    } retire_t;

endpackage

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [`MIPS_REG_ADDR_W-1:0] rs_addr,
    input  logic [`MIPS_REG_ADDR_W-1:0] rt_addr,
    input  logic                        wr_en,
    input  logic [`MIPS_REG_ADDR_W-1:0] wr_addr,
    input  logic [`MIPS_XLEN-1:0]       wr_data,
    output logic [`MIPS_XLEN-1:0]       rs_data,
    output logic [`MIPS_XLEN-1:0]       rt_data
);

    // Architectural registers
    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

    // Clocked write, every entry cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // Register zero never takes a write
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads
    // Index zero always reads as zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- tests/tb_mips_exec.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_exec;

    // Run limit: reset time plus 40 ns per issued instruction or idle cycle
    localparam int RESET_NS = 8 * 20;
    localparam int N_INSTR  = 104;

    logic              clk;
    logic              arst_n;
    logic              instr_valid;
    mips_pkg::instr_u  instr;
    mips_pkg::retire_t retire;

    // Reference model of registers and data memory
    logic [`MIPS_XLEN-1:0] mregs [`MIPS_REG_COUNT];
    logic [`MIPS_XLEN-1:0] mmem  [`MIPS_DMEM_DEPTH];

    int seed         = 37;
    int test_errors  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    mips_exec_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Watchdog
    initial begin
        #(RESET_NS + N_INSTR * 40);
        $display("Timeout: the tests did not finish within the time limit");
        $display("Done: errors found");
        $finish;
    end

    // R-type word, fields in assembly order
    function automatic mips_pkg::instr_u r_word(input logic [5:0] fn, input logic [4:0] rd,
                                                input logic [4:0] rs, input logic [4:0] rt,
                                                input logic [4:0] sh);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    // I-type word
    function automatic mips_pkg::instr_u i_word(input logic [5:0] op, input logic [4:0] rt,
                                                input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic fail_line(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic check_reg_write(input mips_pkg::retire_t got,
                                   input logic [`MIPS_REG_ADDR_W-1:0] idx,
                                   input logic [`MIPS_XLEN-1:0] data);
        if (got.valid !== 1'b1 || got.kind !== mips_pkg::RET_REG_WRITE
                || got.reg_idx !== idx || got.data !== data) begin
            fail_line($sformatf("r%0d expected %h, got valid %b kind %0d r%0d %h",
                                idx, data, got.valid, got.kind, got.reg_idx, got.data));
        end
    endtask

    task automatic check_store(input mips_pkg::retire_t got,
                               input logic [`MIPS_XLEN-1:0] addr,
                               input logic [`MIPS_XLEN-1:0] data);
        if (got.valid !== 1'b1 || got.kind !== mips_pkg::RET_STORE
                || got.addr !== addr || got.data !== data) begin
            fail_line($sformatf("store %h to %h, got valid %b kind %0d data %h addr %h",
                                data, addr, got.valid, got.kind, got.data, got.addr));
        end
    endtask

    task automatic check_none(input mips_pkg::retire_t got);
        if (got.valid !== 1'b1 || got.kind !== mips_pkg::RET_NONE) begin
            fail_line($sformatf("expected NONE, got valid %b kind %0d", got.valid, got.kind));
        end
    endtask

    task automatic check_illegal(input mips_pkg::retire_t got);
        if (got.valid !== 1'b1 || got.kind !== mips_pkg::RET_ILLEGAL) begin
            fail_line($sformatf("expected ILLEGAL, got valid %b kind %0d", got.valid, got.kind));
        end
    endtask

    // Report must stay low one cycle after the last strobe
    task automatic check_idle();
        @(posedge clk);
        #2;
        if (retire.valid !== 1'b0) begin
            fail_line("retire valid high with no instruction issued");
        end
    endtask

    // Called 2 ns after an edge, returns 2 ns after the next one
    task automatic exec(input mips_pkg::instr_u w, output mips_pkg::retire_t got);
        instr       = w;
        instr_valid = 1'b1;
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        got         = retire;
    endtask

    // Predict from the model, issue, check, then update the model
    task automatic run(input mips_pkg::instr_u w);
        mips_pkg::retire_t           got;
        logic [`MIPS_XLEN-1:0]       a;
        logic [`MIPS_XLEN-1:0]       b;
        logic [`MIPS_XLEN-1:0]       imm;
        logic [`MIPS_XLEN-1:0]       addr;
        logic [`MIPS_XLEN-1:0]       res;
        logic [`MIPS_REG_ADDR_W-1:0] dest;
        logic [`MIPS_SHAMT_W-1:0]    sh;
        bit                          illegal;
        bit                          store;
        a       = mregs[w.r.rs];
        b       = mregs[w.r.rt];
        imm     = 32'($signed(w.i.imm));
        addr    = a + imm;
        dest    = w.r.rd;
        sh      = w.r.shamt;
        illegal = 1'b0;
        store   = 1'b0;
        res     = '0;
        if (w.r.opcode == mips_pkg::OP_SPECIAL) begin
            case (w.r.funct)
                mips_pkg::FN_ADDU: res = a + b;
                mips_pkg::FN_SUBU: res = a - b;
                mips_pkg::FN_AND:  res = a & b;
                mips_pkg::FN_OR:   res = a | b;
                mips_pkg::FN_XOR:  res = a ^ b;
                mips_pkg::FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                mips_pkg::FN_SLL:  res = b << sh;
                mips_pkg::FN_SRL:  res = b >> sh;
                mips_pkg::FN_SRA:  res = $signed(b) >>> sh;
                // Only the low 5 bits of rs count
                mips_pkg::FN_SLLV: res = b << a[4:0];
                mips_pkg::FN_SRLV: res = b >> a[4:0];
                mips_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
                default:           illegal = 1'b1;
            endcase
        end else begin
            dest = w.i.rt;
            case (w.i.opcode)
                mips_pkg::OP_ADDIU: res = addr;
                mips_pkg::OP_LW:    res = mmem[addr[`MIPS_DMEM_ADDR_W+1:2]];
                mips_pkg::OP_SW:    store = 1'b1;
                default:            illegal = 1'b1;
            endcase
        end
        exec(w, got);
        if (illegal) begin
            check_illegal(got);
        end else if (store) begin
            check_store(got, addr, b);
            mmem[addr[`MIPS_DMEM_ADDR_W+1:2]] = b;
        end else if (dest == '0) begin
            check_none(got);
        end else begin
            check_reg_write(got, dest, res);
            mregs[dest] = res;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d mismatches", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic test_addiu();
        // Each load adds a random immediate to the register before it
        for (int i = 1; i < 8; i++) begin
            run(i_word(mips_pkg::OP_ADDIU, 5'(i), 5'(i - 1), 16'($random(seed))));
        end
        // Most negative immediate
        run(i_word(mips_pkg::OP_ADDIU, 5'd8, 5'd0, 16'h8000));
        // Dropped write to r0, then r0 must still read zero
        run(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234));
        run(r_word(mips_pkg::FN_OR, 5'd9, 5'd0, 5'd0, 5'd0));
        end_test("addiu");
    endtask

    task automatic test_alu();
        for (int k = 0; k < 4; k++) begin
            run(i_word(mips_pkg::OP_ADDIU, 5'd10, 5'd0, 16'($random(seed))));
            run(i_word(mips_pkg::OP_ADDIU, 5'd11, 5'd0, 16'($random(seed))));
            run(r_word(mips_pkg::FN_ADDU, 5'd12, 5'd10, 5'd11, 5'd0));
            run(r_word(mips_pkg::FN_SUBU, 5'd13, 5'd10, 5'd11, 5'd0));
            run(r_word(mips_pkg::FN_AND, 5'd14, 5'd10, 5'd11, 5'd0));
            run(r_word(mips_pkg::FN_OR, 5'd15, 5'd10, 5'd11, 5'd0));
            run(r_word(mips_pkg::FN_XOR, 5'd16, 5'd10, 5'd11, 5'd0));
            // Compare both ways round
            run(r_word(mips_pkg::FN_SLTU, 5'd17, 5'd10, 5'd11, 5'd0));
            run(r_word(mips_pkg::FN_SLTU, 5'd18, 5'd11, 5'd10, 5'd0));
        end
        end_test("alu");
    endtask

    task automatic test_shifts();
        logic [15:0] v;
        for (int k = 0; k < 3; k++) begin
            v = 16'($random(seed));
            // Sign bit set in the first round
            if (k == 0) begin
                v[15] = 1'b1;
            end
            run(i_word(mips_pkg::OP_ADDIU, 5'd10, 5'd0, v));
            // Amount register, upper bits are noise
            run(i_word(mips_pkg::OP_ADDIU, 5'd11, 5'd0, 16'($random(seed))));
            run(r_word(mips_pkg::FN_SLL, 5'd12, 5'd0, 5'd10, 5'($random(seed))));
            run(r_word(mips_pkg::FN_SRL, 5'd13, 5'd0, 5'd10, 5'($random(seed))));
            run(r_word(mips_pkg::FN_SRA, 5'd14, 5'd0, 5'd10, 5'($random(seed))));
            run(r_word(mips_pkg::FN_SLLV, 5'd15, 5'd11, 5'd10, 5'd0));
            run(r_word(mips_pkg::FN_SRLV, 5'd16, 5'd11, 5'd10, 5'd0));
            run(r_word(mips_pkg::FN_SRAV, 5'd17, 5'd11, 5'd10, 5'd0));
            // Move the low half to the top, then shift it back arithmetically
            run(r_word(mips_pkg::FN_SLL, 5'd18, 5'd0, 5'd10, 5'd16));
            run(r_word(mips_pkg::FN_SRA, 5'd19, 5'd0, 5'd18, 5'($random(seed))));
        end
        end_test("shifts");
    endtask

    task automatic test_mem();
        logic [15:0] off;
        run(i_word(mips_pkg::OP_ADDIU, 5'd20, 5'd0, 16'h0100));
        // Fill all four words first so each load must pick its own address
        for (int k = 0; k < 4; k++) begin
            // First offset is negative
            off = 16'(k * 12 - 8);
            run(i_word(mips_pkg::OP_ADDIU, 5'd21, 5'd0, 16'($random(seed))));
            run(i_word(mips_pkg::OP_SW, 5'd21, 5'd20, off));
        end
        for (int k = 0; k < 4; k++) begin
            off = 16'(k * 12 - 8);
            run(i_word(mips_pkg::OP_LW, 5'd22, 5'd20, off));
        end
        // Never written
        run(i_word(mips_pkg::OP_LW, 5'd23, 5'd0, 16'h0200));
        end_test("load_store");
    endtask

    task automatic test_back_to_back();
        // Every strobe follows the previous one with no gap
        run(i_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'($random(seed))));
        run(r_word(mips_pkg::FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0));
        run(r_word(mips_pkg::FN_SUBU, 5'd3, 5'd2, 5'd1, 5'd0));
        run(r_word(mips_pkg::FN_SLL, 5'd4, 5'd0, 5'd3, 5'd3));
        run(i_word(mips_pkg::OP_SW, 5'd4, 5'd0, 16'h0040));
        run(i_word(mips_pkg::OP_LW, 5'd5, 5'd0, 16'h0040));
        run(r_word(mips_pkg::FN_ADDU, 5'd6, 5'd5, 5'd5, 5'd0));
        check_idle();
        end_test("back_to_back");
    endtask

    task automatic test_illegal();
        // Unknown funct, then unknown opcode, both aimed at r7
        run(r_word(6'h3f, 5'd7, 5'd1, 5'd2, 5'd0));
        run(i_word(6'h3f, 5'd7, 5'd1, 16'h7fff));
        // Byte store is not supported
        run(i_word(6'h28, 5'd21, 5'd20, 16'h0004));
        // Read back r7 and the word the store would have hit
        run(r_word(mips_pkg::FN_OR, 5'd8, 5'd7, 5'd0, 5'd0));
        run(i_word(mips_pkg::OP_LW, 5'd9, 5'd20, 16'h0004));
        end_test("illegal");
    endtask

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        arst_n      = 1'b0;
        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            mmem[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_idle();
        end_test("reset");
        test_addiu();
        test_alu();
        test_shifts();
        test_mem();
        test_back_to_back();
        test_illegal();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
